// ==== Makefile ====
# Verilator simulation of the square follow obstacle

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module square_follow_obstacle_tb -f tb.f
	@out="$$(./obj_dir/Vsquare_follow_obstacle_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== logic/field_geometry_pkg.sv ====
package field_geometry_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // raster types
    ////////////////////////////////////////////////////////////////////////////

    // screen position, wide enough for the full raster
    typedef logic [11:0] coord_t;

    // 4:4:4 colour, red in the top nibble
    typedef logic [11:0] rgb_t;

    ////////////////////////////////////////////////////////////////////////////
    // play field
    ////////////////////////////////////////////////////////////////////////////

    // the walls are drawn on these lines and everything between them,
    // the field is square, 300 x 300 pixels
    localparam coord_t FIELD_TOP    = 12'd317;
    localparam coord_t FIELD_BOTTOM = 12'd617;
    localparam coord_t FIELD_LEFT   = 12'd361;
    localparam coord_t FIELD_RIGHT  = 12'd661;

    ////////////////////////////////////////////////////////////////////////////
    // colours
    ////////////////////////////////////////////////////////////////////////////

    localparam rgb_t WALL_RGB = 12'hfff;    // white

endpackage

// ==== logic/hole_sequencer.sv ====
`timescale 1ns/1ps

module hole_sequencer
    import field_geometry_pkg::*, obstacle_phase_pkg::*;
#(
    parameter integer step_cycles = STEP_CYCLES_DEF,
    parameter integer hold_cycles = HOLD_CYCLES_DEF
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   launch,
    input  logic   abort,
    output coord_t hole_top,
    output coord_t hole_bottom,
    output coord_t hole_left,
    output coord_t hole_right,
    output logic   active,
    output logic   working,
    output logic   done
);

    // timers count from zero, so compare against period - 1
    localparam timer_t STEP_LAST = timer_t'(step_cycles - 1);
    localparam timer_t FAST_LAST = timer_t'((step_cycles + 1) / 2 - 1);
    localparam timer_t HOLD_LAST = timer_t'(hold_cycles - 1);

    // phase targets
    localparam coord_t CLOSE_IN_TOP    = FIELD_TOP + 12'd125;
    localparam coord_t SHRINK_RIGHT    = FIELD_LEFT + 12'd40;
    localparam coord_t DOWN_MID_TOP    = FIELD_TOP + 12'd130;
    localparam coord_t CENTER_LEFT     = FIELD_LEFT + 12'd130;

    phase_t phase, phase_nxt, phase_after;
    timer_t step_cnt, step_nxt;
    timer_t hold_cnt, hold_nxt;
    logic   at_target;
    logic   fast;
    logic   done_nxt;

    coord_t top_nxt, bottom_nxt, left_nxt, right_nxt;
    coord_t top_step, bottom_step, left_step, right_step;    // edges after one step

    ////////////////////////////////////////////////////////////////////////////
    // phase table
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        at_target   = 1'b0;
        fast        = 1'b0;
        phase_after = IDLE;
        top_step    = hole_top;
        bottom_step = hole_bottom;
        left_step   = hole_left;
        right_step  = hole_right;
        case (phase)
            CLOSE_IN: begin
                at_target   = hole_top >= CLOSE_IN_TOP;
                phase_after = SHIFT_RIGHT_UP;
                top_step    = hole_top + 12'd1;
                bottom_step = hole_bottom - 12'd1;
                left_step   = hole_left + 12'd1;
                right_step  = hole_right - 12'd1;
            end
            SHIFT_RIGHT_UP: begin
                at_target   = hole_right >= FIELD_RIGHT;
                phase_after = SHIFT_DOWN;
                top_step    = hole_top - 12'd1;
                bottom_step = hole_bottom - 12'd1;
                left_step   = hole_left + 12'd1;
                right_step  = hole_right + 12'd1;
            end
            SHIFT_DOWN: begin
                at_target   = hole_bottom >= FIELD_BOTTOM;
                phase_after = SHIFT_LEFT_UP;
                top_step    = hole_top + 12'd1;
                bottom_step = hole_bottom + 12'd1;
            end
            SHIFT_LEFT_UP: begin
                at_target   = hole_top <= FIELD_TOP;
                fast        = 1'b1;
                phase_after = SHRINK_LEFT;
                top_step    = hole_top - 12'd1;
                bottom_step = hole_bottom - 12'd1;
                left_step   = hole_left - 12'd1;
                right_step  = hole_right - 12'd1;
            end
            SHRINK_LEFT: begin
                at_target   = hole_right <= SHRINK_RIGHT;
                phase_after = SHIFT_DOWN_MID;
                bottom_step = hole_bottom - 12'd1;
                right_step  = hole_right - 12'd1;
            end
            SHIFT_DOWN_MID: begin
                at_target   = hole_top >= DOWN_MID_TOP;
                fast        = 1'b1;
                phase_after = SHIFT_CENTER;
                top_step    = hole_top + 12'd1;
                bottom_step = hole_bottom + 12'd1;
            end
            SHIFT_CENTER: begin
                at_target   = hole_left >= CENTER_LEFT;
                fast        = 1'b1;
                phase_after = IDLE;         // end of the run
                left_step   = hole_left + 12'd1;
                right_step  = hole_right + 12'd1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        phase_nxt  = phase;
        step_nxt   = step_cnt;
        hold_nxt   = hold_cnt;
        done_nxt   = 1'b0;
        top_nxt    = hole_top;
        bottom_nxt = hole_bottom;
        left_nxt   = hole_left;
        right_nxt  = hole_right;

        if (phase == IDLE) begin
            step_nxt = '0;
            hold_nxt = '0;
            if (launch) begin
                phase_nxt  = CLOSE_IN;
                top_nxt    = FIELD_TOP + 12'd1;     // one pixel in from each wall
                bottom_nxt = FIELD_BOTTOM - 12'd1;
                left_nxt   = FIELD_LEFT + 12'd1;
                right_nxt  = FIELD_RIGHT - 12'd1;
            end
        end else if (abort) begin
            phase_nxt = IDLE;
            step_nxt  = '0;
            hold_nxt  = '0;
        end else if (at_target) begin
            step_nxt = '0;
            if (hold_cnt >= HOLD_LAST) begin
                phase_nxt = phase_after;
                hold_nxt  = '0;
                done_nxt  = (phase == SHIFT_CENTER);
            end else begin
                hold_nxt = hold_cnt + 1'b1;
            end
        end else if (step_cnt >= (fast ? FAST_LAST : STEP_LAST)) begin
            step_nxt   = '0;
            top_nxt    = top_step;
            bottom_nxt = bottom_step;
            left_nxt   = left_step;
            right_nxt  = right_step;
        end else begin
            step_nxt = step_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= IDLE;
            step_cnt <= '0;
            hold_cnt <= '0;
            working  <= 1'b0;
            done     <= 1'b0;
        end else begin
            phase    <= phase_nxt;
            step_cnt <= step_nxt;
            hold_cnt <= hold_nxt;
            working  <= (phase_nxt != IDLE);
            done     <= done_nxt;
        end
    end

    // hole edges, loaded at launch and moved one pixel per step
    always_ff @(posedge clk) begin
        hole_top    <= top_nxt;
        hole_bottom <= bottom_nxt;
        hole_left   <= left_nxt;
        hole_right  <= right_nxt;
    end

    assign active = (phase != IDLE);

endmodule

// ==== logic/obstacle_launch_ctrl.sv ====
`timescale 1ns/1ps

module obstacle_launch_ctrl
    import obstacle_phase_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       done_in,
    input  logic [3:0] selected,
    input  logic       play_selected,
    input  logic       menu_on,
    output logic       launch,
    output logic       abort
);

    logic done_prev;        // done_in one cycle ago
    logic done_rise;
    logic level_ok;

    ////////////////////////////////////////////////////////////////////////////
    // menu decode
    ////////////////////////////////////////////////////////////////////////////

    // only the first cycle of done_in counts, a held level must not
    // restart the obstacle once it has finished
    assign done_rise = done_in && !done_prev;

    assign level_ok = (selected == OBSTACLE_LEVEL) && play_selected;

    ////////////////////////////////////////////////////////////////////////////
    // registered outputs
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            done_prev <= 1'b0;
            launch    <= 1'b0;
            abort     <= 1'b0;
        end else begin
            done_prev <= done_in;
            launch    <= done_rise && level_ok;     // one cycle pulse
            abort     <= menu_on || !play_selected; // level, held while true
        end
    end

endmodule

// ==== logic/obstacle_phase_pkg.sv ====
package obstacle_phase_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // hole motion phases
    ////////////////////////////////////////////////////////////////////////////

    // order matters, the sequencer walks down this list
    typedef enum logic [2:0] {
        IDLE,               // no obstacle on screen
        CLOSE_IN,           // all four walls move inward
        SHIFT_RIGHT_UP,     // hole travels to the upper right corner
        SHIFT_DOWN,         // hole drops to the bottom wall
        SHIFT_LEFT_UP,      // diagonal run back to the top, fast
        SHRINK_LEFT,        // right and bottom walls close in
        SHIFT_DOWN_MID,     // hole drops to mid height, fast
        SHIFT_CENTER        // hole slides right to the centre, fast
    } phase_t;

    ////////////////////////////////////////////////////////////////////////////
    // launch and timing
    ////////////////////////////////////////////////////////////////////////////

    // menu value that picks this obstacle
    localparam logic [3:0] OBSTACLE_LEVEL = 4'd3;

    // cycles per one pixel step at normal rate
    localparam integer STEP_CYCLES_DEF = 3200001;

    // cycles the hole rests at a phase target
    localparam integer HOLD_CYCLES_DEF = 32000000;

    // both timers must hold HOLD_CYCLES_DEF - 1
    localparam integer TIMER_W = 26;

    typedef logic [TIMER_W-1:0] timer_t;

endpackage

// ==== logic/square_follow_obstacle.sv ====
`timescale 1ns/1ps

module square_follow_obstacle
    import field_geometry_pkg::*, obstacle_phase_pkg::*;
#(
    parameter integer step_cycles = STEP_CYCLES_DEF,
    parameter integer hold_cycles = HOLD_CYCLES_DEF
) (
    input  logic       clk,
    input  logic       rst,
    input  coord_t     hcount,
    input  coord_t     vcount,
    input  rgb_t       rgb_in,
    input  logic       done_in,
    input  logic [3:0] selected,
    input  logic       play_selected,
    input  logic       menu_on,
    output rgb_t       rgb_out,
    output coord_t     obstacle_x,
    output coord_t     obstacle_y,
    output logic       working,
    output logic       done
);

    logic   launch, abort;
    logic   active;
    coord_t hole_top, hole_bottom, hole_left, hole_right;

    // menu side
    obstacle_launch_ctrl u_launch_ctrl (
        .clk(clk), .rst(rst),
        .done_in(done_in), .selected(selected),
        .play_selected(play_selected), .menu_on(menu_on),
        .launch(launch), .abort(abort)
    );

    hole_sequencer #(
        .step_cycles(step_cycles),
        .hold_cycles(hold_cycles)
    ) u_hole_sequencer (
        .clk(clk), .rst(rst),
        .launch(launch), .abort(abort),
        .hole_top(hole_top), .hole_bottom(hole_bottom),
        .hole_left(hole_left), .hole_right(hole_right),
        .active(active), .working(working), .done(done)
    );

    // pixel side
    wall_renderer u_wall_renderer (
        .clk(clk), .rst(rst),
        .hcount(hcount), .vcount(vcount), .rgb_in(rgb_in),
        .hole_top(hole_top), .hole_bottom(hole_bottom),
        .hole_left(hole_left), .hole_right(hole_right),
        .active(active),
        .rgb_out(rgb_out), .obstacle_x(obstacle_x), .obstacle_y(obstacle_y)
    );

endmodule

// ==== logic/wall_renderer.sv ====
`timescale 1ns/1ps

module wall_renderer
    import field_geometry_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  coord_t hcount,
    input  coord_t vcount,
    input  rgb_t   rgb_in,
    input  coord_t hole_top,
    input  coord_t hole_bottom,
    input  coord_t hole_left,
    input  coord_t hole_right,
    input  logic   active,
    output rgb_t   rgb_out,
    output coord_t obstacle_x,
    output coord_t obstacle_y
);

    logic in_field;
    logic outside_hole;
    logic wall;

    ////////////////////////////////////////////////////////////////////////////
    // wall test
    ////////////////////////////////////////////////////////////////////////////

    assign in_field = (hcount >= FIELD_LEFT) && (hcount <= FIELD_RIGHT) &&
                      (vcount >= FIELD_TOP)  && (vcount <= FIELD_BOTTOM);

    // edge lines themselves belong to the wall
    assign outside_hole = (vcount <= hole_top)   ||
                          (vcount >= hole_bottom) ||
                          (hcount >= hole_right)  ||
                          (hcount <= hole_left);

    assign wall = active && in_field && outside_hole;

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_out    <= '0;
            obstacle_x <= '0;
            obstacle_y <= '0;
        end else if (wall) begin
            rgb_out    <= WALL_RGB;
            obstacle_x <= hcount;   // tells the player logic where the wall is
            obstacle_y <= vcount;
        end else begin
            rgb_out    <= rgb_in;   // background passes through
            obstacle_x <= '0;
            obstacle_y <= '0;
        end
    end

endmodule

// ==== tb.f ====
logic/field_geometry_pkg.sv
logic/obstacle_phase_pkg.sv
logic/obstacle_launch_ctrl.sv
logic/hole_sequencer.sv
logic/wall_renderer.sv
logic/square_follow_obstacle.sv
test/square_follow_obstacle_tb.sv

// ==== test/obstacle_golden.txt ====
// one row per checkpoint cycle, all values hex, probe pixel output checked a cycle later
// cycle done_in selected play_selected menu_on hcount vcount working done wall
// no launch, wrong level then play deselected
0 0 0 1 0 190 190 0 0 0
4 1 2 1 0 169 13D 0 0 0
8 0 2 1 0 1F4 1F4 0 0 0
C 1 3 0 0 1F4 190 0 0 0
10 0 3 0 0 172 140 0 0 0
// launch, working rises two cycles after done_in
14 1 3 1 0 169 13D 0 0 0
15 1 3 1 0 169 13D 0 0 0
16 1 3 1 0 169 13D 1 0 1
17 1 3 1 0 1F4 1F4 1 0 0
// close in, 25 steps done
7A 1 3 1 0 183 190 1 0 1
7B 1 3 1 0 184 190 1 0 0
// hold at each phase target
206 1 3 1 0 1F4 1BA 1 0 1
207 1 3 1 0 1F4 1BB 1 0 0
20B 1 3 1 0 218 1CC 1 0 1
400 1 3 1 0 280 154 1 0 0
405 1 3 1 0 295 154 1 0 1
7EE 1 3 1 0 276 258 1 0 0
7F3 1 3 1 0 276 237 1 0 1
9E8 1 3 1 0 17C 154 1 0 0
9ED 1 3 1 0 17C 16F 1 0 1
A16 1 3 1 0 17C 165 1 0 1
A17 1 3 1 0 17C 164 1 0 0
B20 1 3 1 0 17C 1D6 1 0 0
B25 1 3 1 0 17C 258 1 0 1
C2A 1 3 1 0 1FE 1D6 1 0 0
C2F 1 3 1 0 1EB 1D6 1 0 1
// end of sequence, done_in still high
C30 1 3 1 0 1EB 1D6 0 1 0
C31 1 3 1 0 169 13D 0 0 0
C44 1 3 1 0 1F4 13D 0 0 0
// second launch, then abort from the menu
C4E 0 3 1 0 1F4 1F4 0 0 0
C58 1 3 1 0 169 13D 0 0 0
C59 1 3 1 0 169 13D 0 0 0
C5A 1 3 1 0 169 13D 1 0 1
CE4 1 3 1 1 169 13D 1 0 1
CE5 1 3 1 1 169 13D 1 0 1
CE6 1 3 1 1 169 13D 0 0 0
CF8 0 3 1 1 1F4 1F4 0 0 0
FFFFFFFF 0 0 0 0 0 0 0 0 0

// ==== test/square_follow_obstacle_tb.sv ====
`timescale 1ns/1ps

module square_follow_obstacle_tb
    import field_geometry_pkg::*;
();

    localparam integer STEP_CYCLES = 4;
    localparam integer HOLD_CYCLES = 6;
    localparam integer FAST_CYCLES = (STEP_CYCLES + 1) / 2;

    // pixel steps per phase at normal rate and at fast rate, plus the seven holds
    localparam integer SEQ_CYCLES = (124 + 125 + 250 + 10) * STEP_CYCLES +
                                    (250 + 130 + 130) * FAST_CYCLES + 7 * HOLD_CYCLES;
    localparam integer ABORT_CYCLES   = 400;   // second launch, abort and idle gaps
    localparam integer TIMEOUT_CYCLES = 2 * SEQ_CYCLES + ABORT_CYCLES;

    localparam integer ROW_WORDS = 10;         // cycle, 6 inputs, 3 expected outputs
    localparam integer MAX_ROWS  = 48;

    // what rgb_out may show one cycle after a pixel
    localparam integer PASS_ONLY    = 0;
    localparam integer WALL_ONLY    = 1;
    localparam integer WALL_OR_PASS = 2;

    // sweep window with a ten pixel margin around the field
    localparam coord_t SWEEP_LEFT   = FIELD_LEFT - 12'd10;
    localparam coord_t SWEEP_RIGHT  = FIELD_RIGHT + 12'd10;
    localparam coord_t SWEEP_TOP    = FIELD_TOP - 12'd10;
    localparam coord_t SWEEP_BOTTOM = FIELD_BOTTOM + 12'd10;

    logic clk, rst;
    coord_t hcount, vcount, obstacle_x, obstacle_y;
    rgb_t rgb_in, rgb_out;
    logic done_in, play_selected, menu_on, working, done;
    logic [3:0] selected;

    logic [31:0] golden [0:ROW_WORDS*MAX_ROWS-1];
    logic [31:0] rnd;
    integer n_rows, row, cyc, end_cycle, i;
    integer checks, value_errors, other_errors, done_pulses;
    integer pend_kind;
    integer wd_cycles = 0;
    logic exp_work, exp_done, have_last;
    coord_t sweep_h, sweep_v, last_h, last_v;
    rgb_t last_rgb;

    square_follow_obstacle #(
        .step_cycles(STEP_CYCLES),
        .hold_cycles(HOLD_CYCLES)
    ) dut (
        .clk(clk), .rst(rst),
        .hcount(hcount), .vcount(vcount), .rgb_in(rgb_in),
        .done_in(done_in), .selected(selected),
        .play_selected(play_selected), .menu_on(menu_on),
        .rgb_out(rgb_out), .obstacle_x(obstacle_x), .obstacle_y(obstacle_y),
        .working(working), .done(done)
    );

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic in_field(input coord_t h, input coord_t v);
        return (h >= FIELD_LEFT) && (h <= FIELD_RIGHT) &&
               (v >= FIELD_TOP) && (v <= FIELD_BOTTOM);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errors++;
            $display("** Error cycle %0d: %s = %h, expected %h", cyc, name, got, exp);
        end
    endtask

    // output of the pixel driven one cycle earlier
    task automatic check_pixel();
        if (pend_kind == WALL_ONLY) begin
            compare_value("rgb_out", rgb_out, WALL_RGB);
            compare_value("obstacle_x", obstacle_x, last_h);
            compare_value("obstacle_y", obstacle_y, last_v);
        end else if (pend_kind == PASS_ONLY) begin
            compare_value("rgb_out", rgb_out, last_rgb);
            compare_value("obstacle_x", obstacle_x, 0);
            compare_value("obstacle_y", obstacle_y, 0);
        end else begin
            checks++;
            assert ((rgb_out === WALL_RGB && obstacle_x === last_h && obstacle_y === last_v) ||
                    (rgb_out === last_rgb && obstacle_x === '0 && obstacle_y === '0)) else begin
                value_errors++;
                $display("** Error cycle %0d: rgb_out = %h obstacle_x = %h obstacle_y = %h, %s %h",
                         cyc, rgb_out, obstacle_x, obstacle_y,
                         "expected wall at the pixel or zero coordinates with rgb_in",
                         last_rgb);
            end
        end
    endtask

    task automatic apply_row(input integer r);
        integer base;
        base          = r * ROW_WORDS;
        done_in       = golden[base + 1][0];
        selected      = golden[base + 2][3:0];
        play_selected = golden[base + 3][0];
        menu_on       = golden[base + 4][0];
        hcount        = golden[base + 5][11:0];   // probe pixel
        vcount        = golden[base + 6][11:0];
        exp_work      = golden[base + 7][0];
        exp_done      = golden[base + 8][0];
        pend_kind     = golden[base + 9][0] ? WALL_ONLY : PASS_ONLY;
    endtask

    task automatic drive_sweep();
        hcount = sweep_h;
        vcount = sweep_v;
        // hole edges are only known at checkpoints
        pend_kind = (exp_work && in_field(sweep_h, sweep_v)) ? WALL_OR_PASS : PASS_ONLY;
        sweep_h = sweep_h + 12'd7;
        if (sweep_h > SWEEP_RIGHT) begin
            sweep_h = SWEEP_LEFT;
            sweep_v = (sweep_v + 12'd5 > SWEEP_BOTTOM) ? SWEEP_TOP : sweep_v + 12'd5;
        end
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        wd_cycles = wd_cycles + 1;
        if (wd_cycles > TIMEOUT_CYCLES + 16) begin
            other_errors++;
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        hcount        = '0;
        vcount        = '0;
        done_in       = 1'b0;
        selected      = '0;
        play_selected = 1'b0;
        menu_on       = 1'b0;
        checks        = 0;
        value_errors  = 0;
        other_errors  = 0;
        done_pulses   = 0;
        exp_work      = 1'b0;
        exp_done      = 1'b0;
        have_last     = 1'b0;
        pend_kind     = PASS_ONLY;
        sweep_h       = SWEEP_LEFT;
        sweep_v       = SWEEP_TOP;
        rnd           = 32'h556cd412;
        rgb_in        = rnd[11:0];     // nonzero background during reset
        row           = 0;
        for (i = 0; i < ROW_WORDS * MAX_ROWS; i++) begin
            golden[i] = '1;
        end
        $readmemh("test/obstacle_golden.txt", golden);
        n_rows = 0;
        while (n_rows < MAX_ROWS && golden[n_rows * ROW_WORDS] !== 32'hffffffff) begin
            n_rows++;
        end
        if (n_rows == 0) begin
            other_errors++;
            $display("golden file test/obstacle_golden.txt could not be read or has no rows");
        end
        end_cycle = (n_rows > 0) ? golden[(n_rows - 1) * ROW_WORDS] + 2 : 0;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        cyc = 0;
        compare_value("working", working, 0);
        compare_value("done", done, 0);
        compare_value("rgb_out", rgb_out, 0);
        compare_value("obstacle_x", obstacle_x, 0);
        compare_value("obstacle_y", obstacle_y, 0);

        for (cyc = 0; cyc <= end_cycle; cyc++) begin
            if (have_last) begin
                check_pixel();
            end
            exp_done = 1'b0;
            if (row < n_rows && golden[row * ROW_WORDS] == cyc) begin
                apply_row(row);
                row++;
            end else begin
                drive_sweep();
            end
            compare_value("working", working, exp_work);
            compare_value("done", done, exp_done);
            if (done === 1'b1) begin
                done_pulses++;
            end
            rnd       = next_random(rnd);
            rgb_in    = rnd[11:0];
            last_h    = hcount;
            last_v    = vcount;
            last_rgb  = rgb_in;
            have_last = 1'b1;
            @(posedge clk);
            #1;
        end

        if (row != n_rows) begin
            other_errors++;
            $display("golden row %0d was never reached, rows must rise in cycle order", row);
        end
        compare_value("done pulse count", done_pulses, 1);
        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
